/* accelerator_matrix_fixed_cfg.svh */
`ifndef ACCELERATOR_MATRIX_FIXED_CFG_SVH
`define ACCELERATOR_MATRIX_FIXED_CFG_SVH

////////////////////////////////////////
// Datapath widths
////////////////////////////////////////

// One signed fixed-point element
// Fraction point position is a caller convention only
`define DATA_SIZE 32

////////////////////////////////////////
// Loop control widths
////////////////////////////////////////

// Size and index fields
// Four bits cover matrices up to 15 by 15
`define CONTROL_SIZE 4

`endif

/* accelerator_matrix_fixed_pkg.sv */
`default_nettype none

`include "accelerator_matrix_fixed_cfg.svh"

package accelerator_matrix_fixed_pkg;

  ////////////////////////////////////////
  // Element and index types
  ////////////////////////////////////////

  // Signed fixed-point word
  typedef logic signed [`DATA_SIZE-1:0] fixed_t;

  // Row or column index, also used for sizes
  typedef logic [`CONTROL_SIZE-1:0] index_t;

  // Operation select, latched at START
  typedef enum logic {
    FIXED_ADD = 1'b0,  // A + B
    FIXED_SUB = 1'b1   // A - B
  } fixed_op_t;

  ////////////////////////////////////////
  // Saturation limits
  ////////////////////////////////////////

  localparam fixed_t FIXED_MAX = {1'b0, {(`DATA_SIZE-1){1'b1}}};
  localparam fixed_t FIXED_MIN = {1'b1, {(`DATA_SIZE-1){1'b0}}};

endpackage

`default_nettype wire

/* accelerator_matrix_fixed_if.sv */
`default_nettype none

////////////////////////////////////////
// Loader to adder
////////////////////////////////////////

interface matrix_pair_if;

  // One-cycle pulse per element pair, no ready
  logic                                  valid;
  // Operands
  accelerator_matrix_fixed_pkg::fixed_t    a;
  accelerator_matrix_fixed_pkg::fixed_t    b;
  // Operation latched at START
  accelerator_matrix_fixed_pkg::fixed_op_t op;
  // Column index at SIZE_J - 1
  logic                                  row_end;
  // Row end on the final row
  logic                                  last;

  modport source(output valid, a, b, op, row_end, last);
  modport sink(input valid, a, b, op, row_end, last);

endinterface

////////////////////////////////////////
// Adder to sequencer
////////////////////////////////////////

interface matrix_sum_if;

  // One-cycle pulse per result
  logic                               valid;
  // Saturated result
  accelerator_matrix_fixed_pkg::fixed_t sum;
  // Flags copied from the pair
  logic                               row_end;
  logic                               last;

  modport source(output valid, sum, row_end, last);
  modport sink(input valid, sum, row_end, last);

endinterface

`default_nettype wire

/* matrix_element_loader.sv */
`default_nettype none

module matrix_element_loader (
  input  wire logic                                 CLK,
  input  wire logic                                 RST,
  input  wire logic                                 START,
  input  wire logic                                 OPERATION,
  input  wire logic                                 a_i_enable,
  input  wire logic                                 a_j_enable,
  input  wire logic                                 b_i_enable,
  input  wire logic                                 b_j_enable,
  input  wire accelerator_matrix_fixed_pkg::index_t size_i,
  input  wire accelerator_matrix_fixed_pkg::index_t size_j,
  input  wire accelerator_matrix_fixed_pkg::fixed_t data_a,
  input  wire accelerator_matrix_fixed_pkg::fixed_t data_b,
  matrix_pair_if.source                             pair
);

  ////////////////////////////////////////
  // State and registers
  ////////////////////////////////////////

  typedef enum logic {
    st_idle,
    st_run
  } state_t;

  state_t state;

  // Run configuration
  accelerator_matrix_fixed_pkg::index_t    size_i_q;
  accelerator_matrix_fixed_pkg::index_t    size_j_q;
  accelerator_matrix_fixed_pkg::fixed_op_t op_q;

  // Current element position
  accelerator_matrix_fixed_pkg::index_t row_idx;
  accelerator_matrix_fixed_pkg::index_t col_idx;

  // Operands already taken in this slot
  logic                                 a_held;
  logic                                 b_held;
  accelerator_matrix_fixed_pkg::fixed_t a_q;
  accelerator_matrix_fixed_pkg::fixed_t b_q;

  logic row_start;
  logic a_take;
  logic b_take;
  logic pair_ready;
  logic col_end;
  logic row_last;

  ////////////////////////////////////////
  // Slot decode
  ////////////////////////////////////////

  // First element of a row uses the I-enables
  assign row_start = (col_idx == '0);

  // Take each operand once per slot, wrong enable kind ignored
  assign a_take = (state == st_run) && !a_held && (row_start ? a_i_enable : a_j_enable);
  assign b_take = (state == st_run) && !b_held && (row_start ? b_i_enable : b_j_enable);

  // Both operands present, either held or arriving now
  assign pair_ready = (state == st_run) && (a_held || a_take) && (b_held || b_take);

  // Position flags, computed here only
  assign col_end  = (col_idx == size_j_q - 1'b1);
  assign row_last = (row_idx == size_i_q - 1'b1);

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= st_idle;
      size_i_q   <= '0;
      size_j_q   <= '0;
      op_q       <= accelerator_matrix_fixed_pkg::FIXED_ADD;
      row_idx    <= '0;
      col_idx    <= '0;
      a_held     <= 1'b0;
      b_held     <= 1'b0;
      pair.valid <= 1'b0;
    end else begin
      // Pulse for one cycle after the slot completes
      pair.valid <= pair_ready;
      case (state)
        st_idle: begin
          // START only honoured here
          if (START) begin
            size_i_q <= size_i;
            size_j_q <= size_j;
            op_q     <= accelerator_matrix_fixed_pkg::fixed_op_t'(OPERATION);
            row_idx  <= '0;
            col_idx  <= '0;
            a_held   <= 1'b0;
            b_held   <= 1'b0;
            state    <= st_run;
          end
        end
        st_run: begin
          if (pair_ready) begin
            // Next slot opens immediately
            a_held <= 1'b0;
            b_held <= 1'b0;
            if (col_end) begin
              col_idx <= '0;
              if (row_last) begin
                state <= st_idle;
              end else begin
                row_idx <= row_idx + 1'b1;
              end
            end else begin
              col_idx <= col_idx + 1'b1;
            end
          end else begin
            if (a_take) a_held <= 1'b1;
            if (b_take) b_held <= 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  ////////////////////////////////////////
  // Operand and pair payload
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (a_take) a_q <= data_a;
    if (b_take) b_q <= data_b;
    if (pair_ready) begin
      // Late operand bypasses its hold register
      pair.a       <= a_held ? a_q : data_a;
      pair.b       <= b_held ? b_q : data_b;
      pair.op      <= op_q;
      pair.row_end <= col_end;
      pair.last    <= col_end && row_last;
    end
  end

endmodule

`default_nettype wire

/* fixed_saturating_adder.sv */
`default_nettype none

`include "accelerator_matrix_fixed_cfg.svh"

module fixed_saturating_adder (
  input wire logic     CLK,
  input wire logic     RST,
  matrix_pair_if.sink  pair,
  matrix_sum_if.source sum
);

  ////////////////////////////////////////
  // Wide arithmetic
  ////////////////////////////////////////

  // One guard bit, enough for any add or subtract incl. -MIN
  logic signed [`DATA_SIZE:0] a_wide;
  logic signed [`DATA_SIZE:0] b_wide;
  logic signed [`DATA_SIZE:0] sum_wide;

  logic                                 overflow;
  accelerator_matrix_fixed_pkg::fixed_t sat;

  // Sign extension
  assign a_wide = {pair.a[`DATA_SIZE-1], pair.a};

  // Subtract as add of negated B
  assign b_wide = (pair.op == accelerator_matrix_fixed_pkg::FIXED_SUB) ?
                  -{pair.b[`DATA_SIZE-1], pair.b} : {pair.b[`DATA_SIZE-1], pair.b};

  assign sum_wide = a_wide + b_wide;

  // Guard and sign bits disagree when out of range
  assign overflow = sum_wide[`DATA_SIZE] ^ sum_wide[`DATA_SIZE-1];

  // Clamp direction from the guard bit
  assign sat = !overflow            ? sum_wide[`DATA_SIZE-1:0] :
               sum_wide[`DATA_SIZE] ? accelerator_matrix_fixed_pkg::FIXED_MIN :
                                      accelerator_matrix_fixed_pkg::FIXED_MAX;

  ////////////////////////////////////////
  // Output register, one cycle
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      sum.valid <= 1'b0;
    end else begin
      sum.valid <= pair.valid;
    end
  end

  // Result and flags travel together
  always_ff @(posedge CLK) begin
    if (pair.valid) begin
      sum.sum     <= sat;
      sum.row_end <= pair.row_end;
      sum.last    <= pair.last;
    end
  end

endmodule

`default_nettype wire

/* matrix_result_sequencer.sv */
`default_nettype none

module matrix_result_sequencer (
  input  wire logic                           CLK,
  input  wire logic                           RST,
  matrix_sum_if.sink                          sum,
  output logic                                READY,
  output logic                                out_i_enable,
  output logic                                out_j_enable,
  output accelerator_matrix_fixed_pkg::fixed_t data_out
);

  ////////////////////////////////////////
  // Strobe decode
  ////////////////////////////////////////

  // Row strobe on every row end but the final one
  logic row_strobe;
  // Final element of the run
  logic done_strobe;

  assign row_strobe  = sum.valid && sum.row_end && !sum.last;
  assign done_strobe = sum.valid && sum.last;

  ////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      data_out     <= '0;
      out_j_enable <= 1'b0;
      out_i_enable <= 1'b0;
      READY        <= 1'b0;
    end else begin
      // One J-strobe per element
      out_j_enable <= sum.valid;
      out_i_enable <= row_strobe;
      // READY replaces the row strobe on the last element
      READY        <= done_strobe;
      // Hold result until the next one
      if (sum.valid) begin
        data_out <= sum.sum;
      end
    end
  end

endmodule

`default_nettype wire

/* accelerator_matrix_fixed_adder.sv */
`default_nettype none

module accelerator_matrix_fixed_adder (
  // Global
  input  wire logic                                 CLK,
  input  wire logic                                 RST,

  // Control
  input  wire logic                                 START,
  output logic                                      READY,
  input  wire logic                                 OPERATION,

  // Element strobes
  input  wire logic                                 DATA_A_IN_I_ENABLE,
  input  wire logic                                 DATA_A_IN_J_ENABLE,
  input  wire logic                                 DATA_B_IN_I_ENABLE,
  input  wire logic                                 DATA_B_IN_J_ENABLE,
  output logic                                      DATA_OUT_I_ENABLE,
  output logic                                      DATA_OUT_J_ENABLE,

  // Data
  input  wire accelerator_matrix_fixed_pkg::index_t SIZE_I_IN,
  input  wire accelerator_matrix_fixed_pkg::index_t SIZE_J_IN,
  input  wire accelerator_matrix_fixed_pkg::fixed_t DATA_A_IN,
  input  wire accelerator_matrix_fixed_pkg::fixed_t DATA_B_IN,
  output accelerator_matrix_fixed_pkg::fixed_t      DATA_OUT
);

  ////////////////////////////////////////
  // Internal links
  ////////////////////////////////////////

  // Operand pairs with position flags
  matrix_pair_if u_pair_if ();
  // Saturated results with position flags
  matrix_sum_if u_sum_if ();

  ////////////////////////////////////////
  // Pipeline, three edges end to end
  ////////////////////////////////////////

  // Input side, sizes and loop indices
  matrix_element_loader u_loader (
    .CLK       (CLK),
    .RST       (RST),
    .START     (START),
    .OPERATION (OPERATION),
    .a_i_enable(DATA_A_IN_I_ENABLE),
    .a_j_enable(DATA_A_IN_J_ENABLE),
    .b_i_enable(DATA_B_IN_I_ENABLE),
    .b_j_enable(DATA_B_IN_J_ENABLE),
    .size_i    (SIZE_I_IN),
    .size_j    (SIZE_J_IN),
    .data_a    (DATA_A_IN),
    .data_b    (DATA_B_IN),
    .pair      (u_pair_if.source)
  );

  // Saturating add or subtract
  fixed_saturating_adder u_adder (
    .CLK (CLK),
    .RST (RST),
    .pair(u_pair_if.sink),
    .sum (u_sum_if.source)
  );

  // Output register and strobes
  matrix_result_sequencer u_sequencer (
    .CLK         (CLK),
    .RST         (RST),
    .sum         (u_sum_if.sink),
    .READY       (READY),
    .out_i_enable(DATA_OUT_I_ENABLE),
    .out_j_enable(DATA_OUT_J_ENABLE),
    .data_out    (DATA_OUT)
  );

endmodule

`default_nettype wire

/* accelerator_matrix_fixed_adder_assertions.sv */
`default_nettype none

module accelerator_matrix_fixed_adder_assertions (
  input wire logic CLK,
  input wire logic RST,
  input wire logic READY,
  input wire logic DATA_OUT_I_ENABLE,
  input wire logic DATA_OUT_J_ENABLE
);

  // Failed check count read back by the testbench
  int violations = 0;

  ////////////////////////////////////////
  // Output strobe protocol
  ////////////////////////////////////////

  // One READY pulse per run
  a_ready_single: assert property (@(posedge CLK) disable iff (RST) READY |=> !READY)
    else begin
      violations++;
      $error("READY held for more than one cycle");
    end

  // Row and done strobes ride on a result strobe
  a_ready_with_j: assert property (@(posedge CLK) disable iff (RST)
    READY |-> DATA_OUT_J_ENABLE)
    else begin
      violations++;
      $error("READY without DATA_OUT_J_ENABLE");
    end

  a_row_with_j: assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_I_ENABLE |-> DATA_OUT_J_ENABLE)
    else begin
      violations++;
      $error("DATA_OUT_I_ENABLE without DATA_OUT_J_ENABLE");
    end

  // Last element gets READY instead of a row strobe
  a_ready_not_row: assert property (@(posedge CLK) disable iff (RST)
    !(READY && DATA_OUT_I_ENABLE))
    else begin
      violations++;
      $error("READY and DATA_OUT_I_ENABLE high together");
    end

  // Quiet outputs right after reset
  a_reset_quiet: assert property (@(posedge CLK)
    $fell(RST) |-> !READY && !DATA_OUT_I_ENABLE && !DATA_OUT_J_ENABLE)
    else begin
      violations++;
      $error("Output strobe high in first cycle after reset");
    end

endmodule

`default_nettype wire

/* accelerator_matrix_fixed_adder_tb.sv */
`default_nettype none

module accelerator_matrix_fixed_adder_tb;

  localparam int          TIMEOUT_CYCLES = 200;
  localparam logic [15:0] LFSR_SEED      = 16'd80;
  localparam int          MODE_PLAIN = 0;
  localparam int          MODE_SAT   = 1;
  localparam int          MODE_ORDER = 2;
  localparam int          MODE_BURST = 3;

  // Expected result, strobes and the edge it must follow
  typedef struct packed {
    accelerator_matrix_fixed_pkg::fixed_t data;
    logic                                 row_end;
    logic                                 ready;
    logic [31:0]                          due;
  } expect_t;

  logic CLK, RST, start, operation, ready, out_i_enable, out_j_enable;
  logic a_i_enable, a_j_enable, b_i_enable, b_j_enable;
  accelerator_matrix_fixed_pkg::index_t size_i, size_j;
  accelerator_matrix_fixed_pkg::fixed_t data_a, data_b, data_out;

  logic [15:0] lfsr;
  int unsigned edge_cnt = 0;
  int unsigned exp_edge = 0;
  expect_t     expect_q[$];
  expect_t     exp_cur;
  logic        exp_present;
  string       test_name;
  int          value_errs, other_errs, protocol_errs;

  accelerator_matrix_fixed_adder u_accelerator_matrix_fixed_adder (
    .CLK               (CLK),
    .RST               (RST),
    .START             (start),
    .READY             (ready),
    .OPERATION         (operation),
    .DATA_A_IN_I_ENABLE(a_i_enable),
    .DATA_A_IN_J_ENABLE(a_j_enable),
    .DATA_B_IN_I_ENABLE(b_i_enable),
    .DATA_B_IN_J_ENABLE(b_j_enable),
    .DATA_OUT_I_ENABLE (out_i_enable),
    .DATA_OUT_J_ENABLE (out_j_enable),
    .SIZE_I_IN         (size_i),
    .SIZE_J_IN         (size_j),
    .DATA_A_IN         (data_a),
    .DATA_B_IN         (data_b),
    .DATA_OUT          (data_out)
  );

  bind accelerator_matrix_fixed_adder accelerator_matrix_fixed_adder_assertions u_assertions (
    .CLK              (CLK),
    .RST              (RST),
    .READY            (READY),
    .DATA_OUT_I_ENABLE(DATA_OUT_I_ENABLE),
    .DATA_OUT_J_ENABLE(DATA_OUT_J_ENABLE)
  );

  always #10 CLK = ~CLK;

  // Rising edges seen so far
  always @(posedge CLK) edge_cnt <= edge_cnt + 1;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      bits = {bits[30:0], fb};
    end
    return bits;
  endfunction

  // Exact sum or difference clamped to the word limits
  function automatic accelerator_matrix_fixed_pkg::fixed_t expected_result(
    input accelerator_matrix_fixed_pkg::fixed_t a, input accelerator_matrix_fixed_pkg::fixed_t b,
    input logic sub);
    longint exact;
    exact = sub ? longint'(a) - longint'(b) : longint'(a) + longint'(b);
    if (exact > longint'(accelerator_matrix_fixed_pkg::FIXED_MAX))
      return accelerator_matrix_fixed_pkg::FIXED_MAX;
    if (exact < longint'(accelerator_matrix_fixed_pkg::FIXED_MIN))
      return accelerator_matrix_fixed_pkg::FIXED_MIN;
    return accelerator_matrix_fixed_pkg::fixed_t'(exact);
  endfunction

  // Small signed values or values near the limits
  function automatic accelerator_matrix_fixed_pkg::fixed_t pick_operand(
    input int mode, input int idx);
    logic [31:0] r;
    r = take_bits(8);
    if (mode != MODE_SAT) return {{24{r[7]}}, r[7:0]};
    case (idx % 4)
      0:       return accelerator_matrix_fixed_pkg::FIXED_MAX - r[2:0];
      1:       return accelerator_matrix_fixed_pkg::FIXED_MIN + r[2:0];
      2:       return {{24{r[7]}}, r[7:0]};
      default: return r[0] ? accelerator_matrix_fixed_pkg::FIXED_MAX :
                             accelerator_matrix_fixed_pkg::FIXED_MIN;
    endcase
  endfunction

  task automatic step_cycle();
    @(posedge CLK);
    #2;
  endtask

  task automatic set_enables(input logic a_on, input logic b_on, input logic row_start);
    a_i_enable = a_on && row_start;
    a_j_enable = a_on && !row_start;
    b_i_enable = b_on && row_start;
    b_j_enable = b_on && !row_start;
  endtask

  task automatic report_mismatch(input string what, input longint expected, input longint actual);
    value_errs++;
    $display("Error %s: %s expected %0d actual %0d", test_name, what, expected, actual);
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // One element slot queued when its later operand is driven
  task automatic drive_slot(input int mode, input logic row_start,
    input accelerator_matrix_fixed_pkg::fixed_t a, input accelerator_matrix_fixed_pkg::fixed_t b,
    input expect_t exp);
    int       order;
    int       gap;
    logic     junk;
    order = (mode == MODE_ORDER) ? int'(take_bits(2) % 3) : 0;
    gap   = (mode == MODE_ORDER) ? int'(take_bits(2)) : 0;
    // Idle cycles with some wrong-kind enables and junk data
    repeat (gap) begin
      junk   = (take_bits(1) != '0);
      data_a = ~a;
      data_b = ~b;
      set_enables(junk, junk, !row_start);
      step_cycle();
    end
    data_a  = a;
    data_b  = b;
    exp.due = edge_cnt + 3;
    case (order)
      0: begin
        set_enables(1'b1, 1'b1, row_start);
        expect_q.push_back(exp);
        step_cycle();
      end
      1: begin
        set_enables(1'b1, 1'b0, row_start);
        step_cycle();
        set_enables(1'b0, 1'b1, row_start);
        exp.due = edge_cnt + 3;
        expect_q.push_back(exp);
        step_cycle();
      end
      default: begin
        set_enables(1'b0, 1'b1, row_start);
        step_cycle();
        set_enables(1'b1, 1'b0, row_start);
        exp.due = edge_cnt + 3;
        expect_q.push_back(exp);
        step_cycle();
      end
    endcase
    set_enables(1'b0, 1'b0, row_start);
  endtask

  // Wait until every queued result has come out
  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (expect_q.size() != 0 && cycles < TIMEOUT_CYCLES) begin
      step_cycle();
      cycles++;
    end
    if (expect_q.size() != 0) begin
      other_errs++;
      $display("Timeout in %s: %0d results never appeared", test_name, expect_q.size());
      expect_q.delete();
    end
  endtask

  task automatic run_matrix(input string name, input int rows, input int cols, input int mode,
    input logic sub);
    accelerator_matrix_fixed_pkg::fixed_t a;
    accelerator_matrix_fixed_pkg::fixed_t b;
    expect_t                              exp;
    int                                   idx;
    test_name = name;
    start     = 1'b1;
    size_i    = accelerator_matrix_fixed_pkg::index_t'(rows);
    size_j    = accelerator_matrix_fixed_pkg::index_t'(cols);
    operation = sub;
    step_cycle();
    start = 1'b0;
    for (int r = 0; r < rows; r++) begin
      for (int c = 0; c < cols; c++) begin
        idx         = r * cols + c;
        a           = pick_operand(mode, idx);
        b           = pick_operand(mode, idx * 3 + 1);
        exp         = '0;
        exp.data    = expected_result(a, b, sub);
        exp.row_end = (c == cols - 1) && (r != rows - 1);
        exp.ready   = (c == cols - 1) && (r == rows - 1);
        // START mid-run with other sizes and operation
        if (mode == MODE_BURST && idx == 1) begin
          start     = 1'b1;
          size_i    = accelerator_matrix_fixed_pkg::index_t'(1);
          size_j    = accelerator_matrix_fixed_pkg::index_t'(1);
          operation = !sub;
        end
        drive_slot(mode, c == 0, a, b, exp);
        start = 1'b0;
      end
    end
    wait_drained();
  endtask

  ////////////////////////////////////////
  // Checking
  ////////////////////////////////////////

  // Pop the expected entry while the result is stable
  always @(negedge CLK) begin
    if (out_j_enable) begin
      exp_present = (expect_q.size() != 0);
      exp_edge    = edge_cnt;
      if (exp_present) exp_cur = expect_q.pop_front();
    end
  end

  a_queued: assert property (@(posedge CLK) disable iff (RST) out_j_enable |-> exp_present)
    else begin
      other_errs++;
      $display("Result strobe in %s with no element outstanding", test_name);
    end

  a_data: assert property (@(posedge CLK) disable iff (RST)
    out_j_enable && exp_present |-> data_out == exp_cur.data)
    else report_mismatch("DATA_OUT", $sampled(exp_cur.data), $sampled(data_out));

  a_row_strobe: assert property (@(posedge CLK) disable iff (RST)
    out_j_enable && exp_present |-> out_i_enable == exp_cur.row_end)
    else report_mismatch("DATA_OUT_I_ENABLE", $sampled(exp_cur.row_end), $sampled(out_i_enable));

  a_ready: assert property (@(posedge CLK) disable iff (RST)
    out_j_enable && exp_present |-> ready == exp_cur.ready)
    else report_mismatch("READY", $sampled(exp_cur.ready), $sampled(ready));

  // Three edges from the sampled enable
  a_latency: assert property (@(posedge CLK) disable iff (RST)
    out_j_enable && exp_present |-> exp_edge == exp_cur.due)
    else report_mismatch("result edge", $sampled(exp_cur.due), $sampled(exp_edge));

  initial begin
    CLK = 1'b0;
    RST = 1'b1;
    start = 1'b0;
    operation = 1'b0;
    set_enables(1'b0, 1'b0, 1'b0);
    size_i = '0;
    size_j = '0;
    data_a = '0;
    data_b = '0;
    lfsr = LFSR_SEED;
    exp_present = 1'b0;
    exp_cur = '0;
    value_errs = 0;
    other_errs = 0;
    test_name = "reset";
    repeat (2) @(posedge CLK);
    #2;
    RST = 1'b0;
    step_cycle();
    run_matrix("add_3x4", 3, 4, MODE_PLAIN, 1'b0);
    run_matrix("sub_3x4", 3, 4, MODE_PLAIN, 1'b1);
    run_matrix("saturate_add", 2, 4, MODE_SAT, 1'b0);
    run_matrix("saturate_sub", 2, 4, MODE_SAT, 1'b1);
    run_matrix("enable_order_add", 4, 3, MODE_ORDER, 1'b0);
    run_matrix("enable_order_sub", 3, 5, MODE_ORDER, 1'b1);
    run_matrix("burst_1x1", 1, 1, MODE_BURST, 1'b0);
    run_matrix("burst_15x2", 15, 2, MODE_BURST, 1'b1);
    step_cycle();
    protocol_errs = u_accelerator_matrix_fixed_adder.u_assertions.violations;
    $display("Errors: value %0d, other %0d, protocol %0d", value_errs, other_errs, protocol_errs);
    if (value_errs + other_errs + protocol_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* accelerator_matrix_fixed_adder.f */
+incdir+.
accelerator_matrix_fixed_pkg.sv
accelerator_matrix_fixed_if.sv
matrix_element_loader.sv
fixed_saturating_adder.sv
matrix_result_sequencer.sv
accelerator_matrix_fixed_adder.sv
accelerator_matrix_fixed_adder_assertions.sv
accelerator_matrix_fixed_adder_tb.sv

/* Bender.yml */
package:
  name: accelerator_matrix_fixed_adder

sources:
  - include_dirs:
      - .
    files:
      - accelerator_matrix_fixed_pkg.sv
      - accelerator_matrix_fixed_if.sv
      - matrix_element_loader.sv
      - fixed_saturating_adder.sv
      - matrix_result_sequencer.sv
      - accelerator_matrix_fixed_adder.sv
  - target: test
    files:
      - accelerator_matrix_fixed_adder_assertions.sv
      - accelerator_matrix_fixed_adder_tb.sv
